// ==== sources.f ====
+incdir+include
rtl/mcu_bus_pkg.sv
rtl/wb_bus_if.sv
rtl/mcu_strobe_sync.sv
rtl/mcu_bus_slave.sv
rtl/mcu_reg_bank.sv
rtl/mcu_fpga_top.sv
tests/tb_clock_gen.sv
tests/tb_mcu_fpga.sv

// ==== Makefile ====
# Verilator build and run for the MCU bus bridge testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module tb_mcu_fpga -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_mcu_fpga); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== tests/tb_mcu_fpga.sv ====
// self-checking testbench, random MCU bus traffic against a register model of the bridge
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

module tb_mcu_fpga;
    import mcu_bus_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_ID     = 8;
    localparam int N_UNMAP  = 8;
    localparam int N_OVER   = 4;
    // worst case, every random write followed by a read
    localparam int OP_COUNT = `REG_COUNT + 2 * N_RANDOM + (N_ID + 2 + `REG_COUNT)
                            + (2 * N_UNMAP + `REG_COUNT) + (N_OVER + 1);
    localparam int CYCLE_LIMIT = 40 * OP_COUNT + 100;

    logic                   clk;
    logic                   rst;
    logic                   nadv;
    logic                   nwe;
    logic                   noe;
    logic [`AD_WIDTH-1:0]   ad_i;
    logic [`AD_WIDTH-1:0]   ad_o;
    logic                   ad_oe;

    // expected contents of the data registers
    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
    string                  test_name;
    int                     error_count = 0;
    int                     test_start_errors = 0;
    int                     release_errors = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    int                     cycle_count = 0;

    tb_clock_gen clock_inst (
        .clk (clk)
    );

    mcu_fpga_top mcu_fpga_top_inst (
        .clk   (clk),
        .rst   (rst),
        .nadv  (nadv),
        .nwe   (nwe),
        .noe   (noe),
        .ad_i  (ad_i),
        .ad_o  (ad_o),
        .ad_oe (ad_oe)
    );

    // region rule: id word, data register or filler
    function automatic logic [`DATA_WIDTH-1:0] expected_read(mcu_region_e region,
                                                             logic [3:0] idx);
        case (region)
            REGION_ID:   return `ID_WORD;
            REGION_REGS: return model[idx];
            default:     return `FILL_WORD;
        endcase
    endfunction

    // reserved bits random, the bank must ignore them
    function automatic logic [`AD_WIDTH-1:0] make_addr(mcu_region_e region, logic [3:0] idx);
        return {region, 11'($urandom), idx, 1'($urandom)};
    endfunction

    task automatic compare_word(input string name, input logic [`AD_WIDTH-1:0] expected,
                                input logic [`AD_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // nadv low 4 cycles, then 8 idle cycles before the next phase
    task automatic drive_address(input logic [`AD_WIDTH-1:0] addr);
        @(negedge clk);
        ad_i = addr;
        nadv = 1'b0;
        repeat (4) @(negedge clk);
        nadv = 1'b1;
        // address still valid where the nadv rise is sampled
        @(negedge clk);
        ad_i = '0;
        repeat (7) @(negedge clk);
    endtask

    task automatic bus_write(input mcu_region_e region, input logic [3:0] idx,
                             input logic [`DATA_WIDTH-1:0] data);
        drive_address(make_addr(region, idx));
        ad_i = {2'b00, data};
        nwe  = 1'b0;
        repeat (4) @(negedge clk);
        nwe = 1'b1;
        // data held past the nwe rise
        repeat (4) @(negedge clk);
        ad_i = '0;
        repeat (4) @(negedge clk);
        // only region regs stores anything
        if (region == REGION_REGS) begin
            model[idx] = data;
        end
    endtask

    task automatic bus_read(input mcu_region_e region, input logic [3:0] idx);
        logic [`DATA_WIDTH-1:0] expected;
        logic [`AD_WIDTH-1:0]   sampled;
        logic                   oe_seen;
        expected = expected_read(region, idx);
        drive_address(make_addr(region, idx));
        // bus must be free before noe falls
        if (ad_oe !== 1'b0) begin
            $display("%s: ad_oe was already high before noe fell", test_name);
            error_count++;
            release_errors++;
        end
        noe = 1'b0;
        repeat (10) @(negedge clk);
        // last cycle of noe low
        sampled = ad_o;
        oe_seen = ad_oe;
        noe     = 1'b1;
        if (oe_seen !== 1'b1) begin
            $display("%s: ad_oe was not high at the end of the read phase", test_name);
            error_count++;
        end else begin
            compare_word(test_name, {2'b00, expected}, sampled);
        end
        repeat (4) @(negedge clk);
        if (ad_oe !== 1'b0) begin
            $display("%s: ad_oe still high 4 cycles after noe rose", test_name);
            error_count++;
            release_errors++;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name,
                     error_count - test_start_errors);
        end
    endtask

    // run limit from the operation count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        mcu_region_e region;
        logic [3:0]  idx;
        void'($urandom(28487));
        rst  = 1'b1;
        nadv = 1'b1;
        nwe  = 1'b1;
        noe  = 1'b1;
        ad_i = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        // 4 rising edges in reset, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        if (ad_oe !== 1'b0) begin
            $display("%s: ad_oe high after reset with noe high", test_name);
            error_count++;
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            bus_read(REGION_REGS, 4'(i));
        end
        finish_test();

        start_test("random_write_read");
        for (int n = 0; n < N_RANDOM; n++) begin
            bus_write(REGION_REGS, 4'($urandom), 16'($urandom));
            if (1'($urandom)) begin
                bus_read(REGION_REGS, 4'($urandom));
            end
        end
        finish_test();

        start_test("identification");
        for (int n = 0; n < N_ID; n++) begin
            bus_read(REGION_ID, 4'($urandom));
        end
        bus_write(REGION_ID, 4'($urandom), 16'($urandom));
        bus_read(REGION_ID, 4'($urandom));
        // data registers untouched by the id write
        for (int i = 0; i < `REG_COUNT; i++) begin
            bus_read(REGION_REGS, 4'(i));
        end
        finish_test();

        start_test("unmapped_regions");
        for (int n = 0; n < N_UNMAP; n++) begin
            // alternate so both unmapped regions are hit
            region = (n % 2 == 1) ? REGION_UNMAP_HI : REGION_UNMAP_LO;
            bus_read(region, 4'($urandom));
            bus_write(region, 4'($urandom), 16'($urandom));
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            bus_read(REGION_REGS, 4'(i));
        end
        finish_test();

        start_test("overwrite");
        idx = 4'($urandom);
        for (int n = 0; n < N_OVER; n++) begin
            bus_write(REGION_REGS, idx, 16'($urandom));
        end
        bus_read(REGION_REGS, idx);
        finish_test();

        // release checks ran inside every read above
        if (release_errors == 0) begin
            tests_passed++;
            $display("test bus_release: pass");
        end else begin
            tests_failed++;
            $display("test bus_release: fail with %0d errors", release_errors);
        end

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
// free-running testbench clock with an 8 ns period, instantiated by the top testbench
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // half of the 8 ns period
    localparam real HALF_PERIOD = 4.0;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// ==== rtl/mcu_fpga_top.sv ====
// FPGA top for the multiplexed MCU bus, the board wrapper adds the AD tristate pad
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

module mcu_fpga_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 nadv,
    input  logic                 nwe,
    input  logic                 noe,
    input  logic [`AD_WIDTH-1:0] ad_i,
    output logic [`AD_WIDTH-1:0] ad_o,
    output logic                 ad_oe
);

    logic [`AD_WIDTH-1:0] ad_sync;
    logic                 adv_rise;
    logic                 we_rise;
    logic                 oe_fall;
    logic                 oe_active;

    // slave to bank
    wb_bus_if wb_if ();

    mcu_strobe_sync sync_inst (
        .clk       (clk),
        .rst       (rst),
        .nadv      (nadv),
        .nwe       (nwe),
        .noe       (noe),
        .ad_i      (ad_i),
        .ad_sync   (ad_sync),
        .adv_rise  (adv_rise),
        .we_rise   (we_rise),
        .oe_fall   (oe_fall),
        .oe_active (oe_active)
    );

    mcu_bus_slave slave_inst (
        .clk       (clk),
        .rst       (rst),
        .ad_sync   (ad_sync),
        .adv_rise  (adv_rise),
        .we_rise   (we_rise),
        .oe_fall   (oe_fall),
        .oe_active (oe_active),
        .wb        (wb_if.master),
        .ad_o      (ad_o),
        .ad_oe     (ad_oe)
    );

    mcu_reg_bank bank_inst (
        .clk (clk),
        .rst (rst),
        .wb  (wb_if.slave)
    );

endmodule

// ==== rtl/mcu_reg_bank.sv ====
// Wishbone register bank: id word, sixteen data registers and filler for unmapped space
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

module mcu_reg_bank (
    input  logic     clk,
    input  logic     rst,
    wb_bus_if.slave  wb
);
    import mcu_bus_pkg::*;

    logic [`DATA_WIDTH-1:0] regs_q [`REG_COUNT];
    mcu_region_e            region;
    logic [3:0]             index;
    logic                   access;
    logic [`DATA_WIDTH-1:0] rd_value;

    // decode from the address view
    assign region = wb.adr.addr.region;
    assign index  = wb.adr.addr.index;

    // first stb cycle only, keeps ack one cycle wide
    assign access = wb.cyc && wb.stb && !wb.ack;

    // read mux per region
    always_comb begin
        case (region)
            REGION_ID: begin
                rd_value = `ID_WORD;
            end
            REGION_REGS: begin
                rd_value = regs_q[index];
            end
            default: begin
                // regions 2 and 3
                rd_value = `FILL_WORD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.ack <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            wb.ack <= access;
            // only region regs takes writes
            if (access && wb.we && (region == REGION_REGS)) begin
                regs_q[index] <= wb.dat_w;
            end
        end
    end

    // read data goes out with ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb.dat_r <= rd_value;
        end
    end

endmodule

// ==== rtl/mcu_bus_slave.sv ====
// turns synchronized MCU bus phases into Wishbone classic cycles and drives read data back
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

module mcu_bus_slave (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`AD_WIDTH-1:0] ad_sync,
    input  logic                 adv_rise,
    input  logic                 we_rise,
    input  logic                 oe_fall,
    input  logic                 oe_active,
    wb_bus_if.master             wb,
    output logic [`AD_WIDTH-1:0] ad_o,
    output logic                 ad_oe
);
    import mcu_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_DRIVE
    } slave_state_e;

    slave_state_e           state_q;
    mcu_ad_word_u           ad_word;
    // address from the last address phase
    mcu_ad_word_u           addr_q;
    logic [`DATA_WIDTH-1:0] wdata_q;
    // read data as it goes out on AD
    mcu_ad_word_u           rd_word_q;
    logic                   cycle_open;

    assign ad_word = ad_sync;

    // cyc and stb follow the state register
    assign cycle_open = (state_q == ST_WRITE) || (state_q == ST_READ);
    assign wb.cyc     = cycle_open;
    assign wb.stb     = cycle_open;
    assign wb.we      = (state_q == ST_WRITE);
    assign wb.adr     = addr_q;
    assign wb.dat_w   = wdata_q;
    assign ad_o       = rd_word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            addr_q  <= '0;
            ad_oe   <= 1'b0;
        end else begin
            // address is not touched while a cycle is in flight
            if (adv_rise && !cycle_open) begin
                addr_q <= ad_word;
            end
            case (state_q)
                ST_IDLE: begin
                    if (we_rise) begin
                        state_q <= ST_WRITE;
                    end else if (oe_fall) begin
                        state_q <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    // drop cyc the cycle after ack
                    if (wb.ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (wb.ack) begin
                        // MCU may already have let go of noe
                        ad_oe   <= oe_active;
                        state_q <= oe_active ? ST_DRIVE : ST_IDLE;
                    end
                end
                ST_DRIVE: begin
                    // hold AD until noe goes high
                    if (!oe_active) begin
                        ad_oe   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // write data taken at the nwe rise
    always_ff @(posedge clk) begin
        if (we_rise && (state_q == ST_IDLE)) begin
            wdata_q <= ad_word.data.value;
        end
    end

    // read data registered on ack
    always_ff @(posedge clk) begin
        if ((state_q == ST_READ) && wb.ack) begin
            rd_word_q.data.unused <= '0;
            rd_word_q.data.value  <= wb.dat_r;
        end
    end

endmodule

// ==== rtl/mcu_strobe_sync.sv ====
// brings the MCU strobes and AD lines into the clk domain and turns strobe edges into pulses
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

module mcu_strobe_sync (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 nadv,
    input  logic                 nwe,
    input  logic                 noe,
    input  logic [`AD_WIDTH-1:0] ad_i,
    output logic [`AD_WIDTH-1:0] ad_sync,
    output logic                 adv_rise,
    output logic                 we_rise,
    output logic                 oe_fall,
    output logic                 oe_active
);

    // strobe bits packed as {noe, nwe, nadv}
    logic [`SYNC_STAGES-1:0][2:0] strobe_pipe;
    logic [2:0]                   strobe_now;
    logic [2:0]                   strobe_prev;
    // one extra stage keeps AD in step with the registered pulses
    logic [`SYNC_STAGES:0][`AD_WIDTH-1:0] ad_pipe;

    assign strobe_now = strobe_pipe[`SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            // strobes idle high
            strobe_pipe <= '1;
            strobe_prev <= '1;
            adv_rise    <= 1'b0;
            we_rise     <= 1'b0;
            oe_fall     <= 1'b0;
        end else begin
            strobe_pipe <= {strobe_pipe[`SYNC_STAGES-2:0], {noe, nwe, nadv}};
            strobe_prev <= strobe_now;
            // end of address and write phases
            adv_rise    <= strobe_now[0] & ~strobe_prev[0];
            we_rise     <= strobe_now[1] & ~strobe_prev[1];
            // start of read phase
            oe_fall     <= ~strobe_now[2] & strobe_prev[2];
        end
    end

    // AD payload pipeline
    always_ff @(posedge clk) begin
        ad_pipe <= {ad_pipe[`SYNC_STAGES-1:0], ad_i};
    end

    assign ad_sync = ad_pipe[`SYNC_STAGES];
    // noe low, same latency as the pulses
    assign oe_active = ~strobe_prev[2];

endmodule

// ==== rtl/wb_bus_if.sv ====
// Wishbone classic bundle between the bus slave (master side) and the register bank
`timescale 1ns/1ps
`include "mcu_bus_macros.svh"

interface wb_bus_if;
    import mcu_bus_pkg::*;

    logic                   cyc;
    logic                   stb;
    logic                   we;
    // full bus word, the bank decodes the address view
    mcu_ad_word_u           adr;
    logic [`DATA_WIDTH-1:0] dat_w;
    logic [`DATA_WIDTH-1:0] dat_r;
    // one cycle per transfer
    logic                   ack;

    // bus slave side
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // register bank side
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== rtl/mcu_bus_pkg.sv ====
// shared types for the MCU bus bridge, imported by the slave, the register bank and the testbench
`include "mcu_bus_macros.svh"

package mcu_bus_pkg;

    // top two address bits select the region
    typedef enum logic [1:0] {
        REGION_ID       = 2'd0,
        REGION_REGS     = 2'd1,
        REGION_UNMAP_LO = 2'd2,
        REGION_UNMAP_HI = 2'd3
    } mcu_region_e;

    // address phase layout, index lands on bits 4:1
    typedef struct packed {
        mcu_region_e               region;
        logic [`AD_WIDTH-8:0]      rsvd_hi;
        logic [3:0]                index;
        logic                      rsvd_lo;
    } mcu_ad_addr_t;

    // data phase layout
    typedef struct packed {
        logic [`AD_WIDTH-`DATA_WIDTH-1:0] unused;
        logic [`DATA_WIDTH-1:0]           value;
    } mcu_ad_data_t;

    // same 18 bits, read as address or as data
    typedef union packed {
        mcu_ad_addr_t addr;
        mcu_ad_data_t data;
    } mcu_ad_word_u;

endpackage

// ==== include/mcu_bus_macros.svh ====
// bus widths, synchronizer depth and register bank constants, include wherever a size is needed
`ifndef MCU_BUS_MACROS_SVH
`define MCU_BUS_MACROS_SVH

// multiplexed address/data lines from the MCU
`define AD_WIDTH 18

// data sits in the low bits of the bus word
`define DATA_WIDTH 16

// flops per asynchronous input before use
`define SYNC_STAGES 2

// data registers in region 1
`define REG_COUNT 16

// region 0 read value
`define ID_WORD 16'hA55A

// read value for regions 2 and 3
`define FILL_WORD 16'hDEAD

`endif
